// ==== logic/v_cu_pkg.sv ====
package v_cu_pkg;

   // vsetvli / vsetvl view of the instruction word
   typedef struct packed {
      logic [1:0] form;     // 2'b10 marks vsetvl
      logic [1:0] zimm_hi;
      logic       vma;      // mask agnostic
      logic       vta;      // tail agnostic
      logic       lmul_hi;  // fractional lmul
      logic [2:0] sew;
      logic [1:0] lmul_lo;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } v_cfg_fmt_t;

   // OPIV*/OPMV* arithmetic view
   typedef struct packed {
      logic [5:0] funct6;
      logic       vm;       // 0 = masked
      logic [4:0] vs2;
      logic [4:0] vs1_imm;  // vs1, rs1 or simm5
      logic [2:0] funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
   } v_arith_fmt_t;

   typedef union packed {
      v_cfg_fmt_t   cfg;
      v_arith_fmt_t ar;
   } v_instr_u;

   // class strobe bit positions
   localparam int INSTR_CLS_W = 12;
   localparam int CLS_CONFIG  = 11;
   localparam int CLS_OPIVX   = 10;
   localparam int CLS_OPIVI   = 9;
   localparam int CLS_OPIVV   = 8;
   localparam int CLS_OPMVX   = 7;
   localparam int CLS_OPMVV   = 6;
   localparam int CLS_LOAD    = 5;
   localparam int CLS_ILOAD   = 4;
   localparam int CLS_STORE   = 3;
   localparam int CLS_ISTORE  = 2;

   // lane instruction type
   localparam logic [2:0] IT_NORMAL    = 3'd0;
   localparam logic [2:0] IT_REDUCTION = 3'd1;
   localparam logic [2:0] IT_STORE     = 3'd2;
   localparam logic [2:0] IT_ISTORE    = 3'd3;
   localparam logic [2:0] IT_LOAD      = 3'd4;
   localparam logic [2:0] IT_ILOAD     = 3'd5;
   localparam logic [2:0] IT_SLIDE     = 3'd6;
   localparam logic [2:0] IT_INVALID   = 3'd7;

   // opmode, bits 6:5 hold the group
   localparam int ALU_OPMODE_W = 9;
   localparam logic [1:0] OPG_MUL = 2'b01;
   localparam logic [ALU_OPMODE_W-1:0] OP_NONE      = 9'h000;
   localparam logic [ALU_OPMODE_W-1:0] OP_ADD       = 9'h001;  // add/sub group
   localparam logic [ALU_OPMODE_W-1:0] OP_ADDU      = 9'h002;
   localparam logic [ALU_OPMODE_W-1:0] OP_SUB       = 9'h003;
   localparam logic [ALU_OPMODE_W-1:0] OP_SUBU      = 9'h004;
   localparam logic [ALU_OPMODE_W-1:0] OP_MUL       = 9'h021;  // multiply group
   localparam logic [ALU_OPMODE_W-1:0] OP_MULU      = 9'h022;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULSU     = 9'h023;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULH      = 9'h024;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULHU     = 9'h025;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULHSU    = 9'h026;
   localparam logic [ALU_OPMODE_W-1:0] OP_MUL_ADD   = 9'h027;
   localparam logic [ALU_OPMODE_W-1:0] OP_MUL_SUB   = 9'h028;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULU_ADD  = 9'h029;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULUS_ADD = 9'h02a;
   localparam logic [ALU_OPMODE_W-1:0] OP_MULSU_ADD = 9'h02b;
   localparam logic [ALU_OPMODE_W-1:0] OP_AND       = 9'h041;  // logic group
   localparam logic [ALU_OPMODE_W-1:0] OP_OR        = 9'h042;
   localparam logic [ALU_OPMODE_W-1:0] OP_XOR       = 9'h043;
   localparam logic [ALU_OPMODE_W-1:0] OP_ANDNOT    = 9'h044;
   localparam logic [ALU_OPMODE_W-1:0] OP_ORNOT     = 9'h045;
   localparam logic [ALU_OPMODE_W-1:0] OP_NAND      = 9'h046;
   localparam logic [ALU_OPMODE_W-1:0] OP_NOR       = 9'h047;
   localparam logic [ALU_OPMODE_W-1:0] OP_XNOR      = 9'h048;
   localparam logic [ALU_OPMODE_W-1:0] OP_SEQ       = 9'h061;  // compare/shift group
   localparam logic [ALU_OPMODE_W-1:0] OP_SNEQ      = 9'h062;
   localparam logic [ALU_OPMODE_W-1:0] OP_SLT       = 9'h063;
   localparam logic [ALU_OPMODE_W-1:0] OP_SLTU      = 9'h064;
   localparam logic [ALU_OPMODE_W-1:0] OP_SLE       = 9'h065;
   localparam logic [ALU_OPMODE_W-1:0] OP_SLEU      = 9'h066;
   localparam logic [ALU_OPMODE_W-1:0] OP_SGT       = 9'h067;
   localparam logic [ALU_OPMODE_W-1:0] OP_SGTU      = 9'h068;
   localparam logic [ALU_OPMODE_W-1:0] OP_SLL       = 9'h069;
   localparam logic [ALU_OPMODE_W-1:0] OP_SRL       = 9'h06a;
   localparam logic [ALU_OPMODE_W-1:0] OP_SRA       = 9'h06b;

   // operand-2 source
   localparam logic [1:0] OP2_VV   = 2'd0;
   localparam logic [1:0] OP2_VX   = 2'd1;
   localparam logic [1:0] OP2_VI   = 2'd2;
   localparam logic [1:0] OP2_NONE = 2'd3;

   localparam logic SLIDE_FAST = 1'b1;
   localparam logic SLIDE_SLOW = 1'b0;

   // lane latencies in cycles
   localparam int VRF_DELAY     = 2;
   localparam int ALU_DELAY     = 7;
   localparam int RED_MUL_DELAY = 8;

   localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
   localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;

endpackage

// ==== logic/v_instr_decode.sv ====
`timescale 1ns/1ps

module v_instr_decode
   import v_cu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [INSTR_CLS_W-1:0] instr_vld_i,     // one-hot class strobe
   input  logic [31:0]            vector_instr_i,
   input  logic [31:0]            scalar_rs1_i,
   output v_instr_u               instr_q_o,
   output logic [INSTR_CLS_W-1:0] cls_q_o,
   output logic [31:0]            rs1_q_o,
   output logic [2:0]             inst_type_o,
   output logic                   reduction_o,
   output logic                   slide_o,
   output logic                   widening_o,
   output logic [1:0]             op2_sel_o,
   output logic [31:0]            alu_x_data_o,
   output logic [4:0]             alu_imm_o,
   output logic                   vector_mask_o
);

   logic [2:0] f6_hi;     // funct6 upper bits
   logic       is_arith;  // any OPIV*/OPMV* class
   logic       non_cfg;   // valid and not vset*

   // class strobe
   always_ff @(posedge clk)
   begin
      if (!rstn)
         cls_q_o <= '0;
      else
         cls_q_o <= instr_vld_i;
   end

   // instruction word and scalar operand
   always_ff @(posedge clk)
   begin
      instr_q_o <= vector_instr_i;
      rs1_q_o   <= scalar_rs1_i;
   end

   assign f6_hi    = instr_q_o.ar.funct6[5:3];
   assign is_arith = |cls_q_o[CLS_OPIVX:CLS_OPMVV];
   assign non_cfg  = (|cls_q_o) && !cls_q_o[CLS_CONFIG];

   // vredsum..vredmax in OPMV, vwredsum in OPIVV
   assign reduction_o = ((cls_q_o[CLS_OPMVV] || cls_q_o[CLS_OPMVX]) && f6_hi == 3'b000) ||
                        (cls_q_o[CLS_OPIVV] && f6_hi == 3'b110);
   assign slide_o     = non_cfg && (instr_q_o.ar.funct6 == F6_SLIDEUP ||
                                    instr_q_o.ar.funct6 == F6_SLIDEDOWN);
   assign widening_o  = is_arith && (f6_hi == 3'b110 || f6_hi == 3'b111);

   // memory classes first, then reduction and slide
   always_comb
   begin
      if (cls_q_o[CLS_STORE])
         inst_type_o = IT_STORE;
      else if (cls_q_o[CLS_ISTORE])
         inst_type_o = IT_ISTORE;
      else if (cls_q_o[CLS_LOAD])
         inst_type_o = IT_LOAD;
      else if (cls_q_o[CLS_ILOAD])
         inst_type_o = IT_ILOAD;
      else if (reduction_o)
         inst_type_o = IT_REDUCTION;
      else if (slide_o)
         inst_type_o = IT_SLIDE;
      else if (non_cfg)
         inst_type_o = IT_NORMAL;
      else
         inst_type_o = IT_INVALID;  // vset* or idle
   end

   assign op2_sel_o = (cls_q_o[CLS_OPIVV] || cls_q_o[CLS_OPMVV]) ? OP2_VV :
                      (cls_q_o[CLS_OPIVX] || cls_q_o[CLS_OPMVX]) ? OP2_VX :
                      cls_q_o[CLS_OPIVI]                         ? OP2_VI : OP2_NONE;

   assign alu_x_data_o  = rs1_q_o;
   assign alu_imm_o     = instr_q_o.ar.vs1_imm;  // simm5 field
   assign vector_mask_o = ~instr_q_o.ar.vm;

   // scheduler sends one class per cycle
   a_cls_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(cls_q_o))
      else $error("instruction class strobe has more than one bit set");

endmodule

// ==== logic/v_config_unit.sv ====
`timescale 1ns/1ps

module v_config_unit
   import v_cu_pkg::*;
#(
   parameter int VLEN = 4096
)
(
   input  logic                   clk,
   input  logic                   rstn,
   input  v_instr_u               instr_q_i,
   input  logic [INSTR_CLS_W-1:0] cls_q_i,
   input  logic [31:0]            rs1_q_i,
   output logic [2:0]             sew_o,
   output logic [2:0]             lmul_o,
   output logic [31:0]            vl_o
);

   // vlmax per {lmul, sew}, lmul 4 reserved
   function automatic logic [63:0][31:0] init_vlmax();
      logic [63:0][31:0] tbl;
      tbl = '0;
      for (int lm = 0; lm < 8; lm++)
      begin
         for (int sw = 0; sw < 8; sw++)
         begin
            if (lm < 4)
               tbl[lm*8+sw] = 32'(((VLEN/8) >> sw) << lm);
            else if (lm > 4)
               tbl[lm*8+sw] = 32'(((VLEN/8) >> sw) / (2**(8-lm)));  // mf8..mf2
         end
      end
      return tbl;
   endfunction

   localparam logic [63:0][31:0] VLMAX_TBL = init_vlmax();

   logic [2:0]  sew_nxt;
   logic [2:0]  lmul_nxt;
   logic [31:0] vlmax;
   logic [31:0] vl_nxt;

   always_comb
   begin
      if (instr_q_i.cfg.form == 2'b10)  // vsetvl takes vtype from rs1
      begin
         lmul_nxt = rs1_q_i[2:0];
         sew_nxt  = rs1_q_i[5:3];
      end
      else
      begin
         lmul_nxt = {instr_q_i.cfg.lmul_hi, instr_q_i.cfg.lmul_lo};
         sew_nxt  = instr_q_i.cfg.sew;
      end
   end

   assign vlmax = VLMAX_TBL[{lmul_nxt, sew_nxt}];

   // avl from rs1, else vlmax when rd set, else keep
   assign vl_nxt = (instr_q_i.cfg.rs1 != 5'd0) ? rs1_q_i :
                   (instr_q_i.cfg.rd != 5'd0)  ? vlmax   : vl_o;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         sew_o  <= 3'b010;  // e32, m1
         lmul_o <= 3'b000;
         vl_o   <= 32'(VLEN/32);
      end
      else if (cls_q_i[CLS_CONFIG])
      begin
         sew_o  <= sew_nxt;
         lmul_o <= lmul_nxt;
         vl_o   <= vl_nxt;
      end
   end

   // lanes handle e8..e32 only
   a_sew_range: assert property (@(posedge clk) disable iff (!rstn)
      cls_q_i[CLS_CONFIG] |=> (sew_o <= 3'b010))
      else $error("committed SEW wider than 32 bits");

endmodule

// ==== logic/v_alu_opmode_decoder.sv ====
`timescale 1ns/1ps

module v_alu_opmode_decoder
   import v_cu_pkg::*;
(
   input  v_instr_u                  instr_q_i,
   input  logic [INSTR_CLS_W-1:0]    cls_q_i,
   output logic [ALU_OPMODE_W-1:0]   alu_opmode_o
);

   logic [5:0] f6;

   assign f6 = instr_q_i.ar.funct6;

   always_comb
   begin
      alu_opmode_o = OP_NONE;
      if (|cls_q_i[CLS_OPIVX:CLS_OPIVV])  // OPIVV, OPIVX, OPIVI
      begin
         case (f6)
            6'b000000: alu_opmode_o = OP_ADD;
            6'b000010: alu_opmode_o = OP_SUB;
            6'b000011: alu_opmode_o = OP_SUB;   // vrsub
            6'b000100: alu_opmode_o = OP_SLTU;  // vminu
            6'b000101: alu_opmode_o = OP_SLT;   // vmin
            6'b000110: alu_opmode_o = OP_SGTU;  // vmaxu
            6'b000111: alu_opmode_o = OP_SGT;   // vmax
            6'b001001: alu_opmode_o = OP_AND;
            6'b001010: alu_opmode_o = OP_OR;
            6'b001011: alu_opmode_o = OP_XOR;
            6'b010000: alu_opmode_o = OP_ADD;   // vadc
            6'b010001: alu_opmode_o = OP_ADD;   // vmadc
            6'b010010: alu_opmode_o = OP_SUB;   // vsbc
            6'b010011: alu_opmode_o = OP_SUB;   // vmsbc
            6'b011000: alu_opmode_o = OP_SEQ;
            6'b011001: alu_opmode_o = OP_SNEQ;
            6'b011010: alu_opmode_o = OP_SLTU;
            6'b011011: alu_opmode_o = OP_SLT;
            6'b011100: alu_opmode_o = OP_SLEU;
            6'b011101: alu_opmode_o = OP_SLE;
            6'b011110: alu_opmode_o = OP_SGTU;
            6'b011111: alu_opmode_o = OP_SGT;
            6'b100000: alu_opmode_o = OP_ADDU;  // vsaddu
            6'b100001: alu_opmode_o = OP_ADD;   // vsadd
            6'b100010: alu_opmode_o = OP_SUBU;  // vssubu
            6'b100011: alu_opmode_o = OP_SUB;   // vssub
            6'b100101: alu_opmode_o = OP_SLL;
            6'b100111: alu_opmode_o = OP_MUL;   // vsmul
            6'b101000: alu_opmode_o = OP_SRL;
            6'b101001: alu_opmode_o = OP_SRA;
            6'b101010: alu_opmode_o = OP_SRL;   // vssrl, rounding
            6'b101011: alu_opmode_o = OP_SRA;   // vssra, rounding
            6'b101100: alu_opmode_o = OP_SRL;   // vnsrl narrowing
            6'b101101: alu_opmode_o = OP_SRA;   // vnsra narrowing
            6'b101110: alu_opmode_o = OP_SRL;   // vnclipu
            6'b101111: alu_opmode_o = OP_SRL;   // vnclip
            6'b110000: alu_opmode_o = OP_ADD;   // vwredsumu
            6'b110001: alu_opmode_o = OP_ADD;   // vwredsum
            default:   alu_opmode_o = OP_NONE;  // slides, gather, merge
         endcase
      end
      else if (|cls_q_i[CLS_OPMVX:CLS_OPMVV])  // OPMVV, OPMVX
      begin
         case (f6)
            6'b000000: alu_opmode_o = OP_ADD;   // vredsum
            6'b000001: alu_opmode_o = OP_AND;   // vredand
            6'b000010: alu_opmode_o = OP_OR;
            6'b000011: alu_opmode_o = OP_XOR;
            6'b000100: alu_opmode_o = OP_SLTU;  // vredminu
            6'b000101: alu_opmode_o = OP_SLT;
            6'b000110: alu_opmode_o = OP_SGTU;  // vredmaxu
            6'b000111: alu_opmode_o = OP_SGT;
            6'b001000: alu_opmode_o = OP_ADDU;  // vaaddu
            6'b001001: alu_opmode_o = OP_ADD;   // vaadd
            6'b001010: alu_opmode_o = OP_SUBU;  // vasubu
            6'b001011: alu_opmode_o = OP_SUB;   // vasub
            6'b011000: alu_opmode_o = OP_ANDNOT;  // mask logic from here
            6'b011001: alu_opmode_o = OP_AND;
            6'b011010: alu_opmode_o = OP_OR;
            6'b011011: alu_opmode_o = OP_XOR;
            6'b011100: alu_opmode_o = OP_ORNOT;
            6'b011101: alu_opmode_o = OP_NAND;
            6'b011110: alu_opmode_o = OP_NOR;
            6'b011111: alu_opmode_o = OP_XNOR;
            6'b100100: alu_opmode_o = OP_MULHU;
            6'b100101: alu_opmode_o = OP_MUL;
            6'b100110: alu_opmode_o = OP_MULHSU;
            6'b100111: alu_opmode_o = OP_MULH;
            6'b101001: alu_opmode_o = OP_MUL_ADD;  // vmadd
            6'b101011: alu_opmode_o = OP_MUL_SUB;  // vnmsub
            6'b101101: alu_opmode_o = OP_MUL_ADD;  // vmacc
            6'b101111: alu_opmode_o = OP_MUL_SUB;  // vnmsac
            6'b110000: alu_opmode_o = OP_ADDU;  // vwaddu
            6'b110001: alu_opmode_o = OP_ADD;   // vwadd
            6'b110010: alu_opmode_o = OP_SUBU;
            6'b110011: alu_opmode_o = OP_SUB;
            6'b110100: alu_opmode_o = OP_ADDU;  // .w forms
            6'b110101: alu_opmode_o = OP_ADD;
            6'b110110: alu_opmode_o = OP_SUBU;
            6'b110111: alu_opmode_o = OP_SUB;
            6'b111000: alu_opmode_o = OP_MULU;  // vwmulu
            6'b111010: alu_opmode_o = OP_MULSU; // vwmulsu
            6'b111011: alu_opmode_o = OP_MUL;   // vwmul
            6'b111100: alu_opmode_o = OP_MULU_ADD;   // vwmaccu
            6'b111101: alu_opmode_o = OP_MUL_ADD;    // vwmacc
            6'b111110: alu_opmode_o = OP_MULUS_ADD;  // vwmaccus
            6'b111111: alu_opmode_o = OP_MULSU_ADD;  // vwmaccsu
            default:   alu_opmode_o = OP_NONE;  // div/rem, unary, compress
         endcase
      end
   end

endmodule

// ==== logic/v_slide_ctrl.sv ====
`timescale 1ns/1ps

module v_slide_ctrl
   import v_cu_pkg::*;
#(
   parameter int VLEN      = 4096,
   parameter int VLANE_NUM = 16
)
(
   input  v_instr_u                  instr_q_i,
   input  logic [INSTR_CLS_W-1:0]    cls_q_i,
   input  logic [31:0]               rs1_q_i,
   input  logic [2:0]                sew_i,          // committed sew
   input  logic                      slide_i,
   input  logic                      widening_i,
   input  logic                      reduction_i,
   input  logic [ALU_OPMODE_W-1:0]   alu_opmode_i,
   output logic                      slide_type_o,
   output logic                      up_down_slide_o,  // 1 = up
   output logic [31:0]               slide_amount_o,   // in bytes
   output logic [1:0]                wdata_width_o,
   output logic [$clog2(VLEN/VLANE_NUM)-1:0] inst_delay_o
);

   localparam int          DELAY_W   = $clog2(VLEN/VLANE_NUM);  // per-lane vl bits
   localparam logic [31:0] FAST_BASE = 32'(VLANE_NUM*4);        // one word per lane at e8

   logic [31:0] fast_amt;

   assign fast_amt     = FAST_BASE >> sew_i;
   assign slide_type_o = (rs1_q_i == fast_amt) ? SLIDE_FAST : SLIDE_SLOW;

   assign up_down_slide_o = (instr_q_i.ar.funct6 != F6_SLIDEDOWN);

   // element offset scaled to bytes
   assign slide_amount_o = cls_q_i[CLS_OPIVI] ? {27'd0, instr_q_i.ar.vs1_imm} << sew_i :
                           cls_q_i[CLS_OPIVX] ? rs1_q_i << sew_i : 32'd1 << sew_i;

   assign wdata_width_o = (slide_i && slide_type_o == SLIDE_SLOW) ? 2'b01 :
                          widening_i ? 2'(sew_i + 3'd2) : 2'(sew_i + 3'd1);

   // mul reductions go through the multiplier stages
   assign inst_delay_o = (reduction_i && alu_opmode_i[6:5] == OPG_MUL) ? DELAY_W'(RED_MUL_DELAY) :
                         slide_i ? DELAY_W'(VRF_DELAY) : DELAY_W'(ALU_DELAY);

endmodule

// ==== logic/v_cu.sv ====
`timescale 1ns/1ps

module v_cu
   import v_cu_pkg::*;
#(
   parameter int VLEN      = 4096,
   parameter int VLANE_NUM = 16
)
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [INSTR_CLS_W-1:0] instr_vld_i,
   input  logic [31:0]            vector_instr_i,
   input  logic [31:0]            scalar_rs1_i,
   output logic [2:0]             sew_o,
   output logic [2:0]             lmul_o,
   output logic [31:0]            vl_o,
   output logic [2:0]             inst_type_o,
   output logic                   reduction_op_o,
   output logic [1:0]             op2_sel_o,
   output logic [31:0]            alu_x_data_o,
   output logic [4:0]             alu_imm_o,
   output logic [ALU_OPMODE_W-1:0] alu_opmode_o,
   output logic                   vector_mask_o,
   output logic [1:0]             wdata_width_o,
   output logic [$clog2(VLEN/VLANE_NUM)-1:0] inst_delay_o,
   output logic                   slide_type_o,
   output logic                   up_down_slide_o,
   output logic [31:0]            slide_amount_o
);

   v_instr_u                  instr_q;  // registered instruction
   logic [INSTR_CLS_W-1:0]    cls_q;
   logic [31:0]               rs1_q;
   logic                      slide;
   logic                      widening;

   v_instr_decode u_decode (
      .clk(clk), .rstn(rstn),
      .instr_vld_i(instr_vld_i), .vector_instr_i(vector_instr_i),
      .scalar_rs1_i(scalar_rs1_i),
      .instr_q_o(instr_q), .cls_q_o(cls_q), .rs1_q_o(rs1_q),
      .inst_type_o(inst_type_o), .reduction_o(reduction_op_o),
      .slide_o(slide), .widening_o(widening), .op2_sel_o(op2_sel_o),
      .alu_x_data_o(alu_x_data_o), .alu_imm_o(alu_imm_o),
      .vector_mask_o(vector_mask_o)
   );

   v_config_unit #(.VLEN(VLEN)) u_config (
      .clk(clk), .rstn(rstn),
      .instr_q_i(instr_q), .cls_q_i(cls_q), .rs1_q_i(rs1_q),
      .sew_o(sew_o), .lmul_o(lmul_o), .vl_o(vl_o)
   );

   v_alu_opmode_decoder u_opmode (
      .instr_q_i(instr_q), .cls_q_i(cls_q), .alu_opmode_o(alu_opmode_o)
   );

   // slide amount uses the sew committed so far
   v_slide_ctrl #(.VLEN(VLEN), .VLANE_NUM(VLANE_NUM)) u_slide (
      .instr_q_i(instr_q), .cls_q_i(cls_q), .rs1_q_i(rs1_q), .sew_i(sew_o),
      .slide_i(slide), .widening_i(widening), .reduction_i(reduction_op_o),
      .alu_opmode_i(alu_opmode_o),
      .slide_type_o(slide_type_o), .up_down_slide_o(up_down_slide_o),
      .slide_amount_o(slide_amount_o), .wdata_width_o(wdata_width_o),
      .inst_delay_o(inst_delay_o)
   );

endmodule

// ==== include/v_cu_tb_cases.svh ====
`ifndef V_CU_TB_CASES_SVH
`define V_CU_TB_CASES_SVH

// columns: cls, instr, rs1, rnd, chk, itype, op2, opmode, red, wdata width, delay,
//          slide type, up, amount, then sew, lmul, vl after a config row
task automatic fill_table();
   // integer and multiply decode at reset vtype e32
   add_row("vadd_vv", row_t'{S_IVV, enc_ar(6'b000000, 1'b1, 5'd2, 5'd3, 3'b000), 32'd0, 1'b0,
      CK_WDW | CK_DLY, IT_NORMAL, OP2_VV, OP_ADD, 1'b0, 2'd3, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vand_vx_m", row_t'{S_IVX, enc_ar(6'b001001, 1'b0, 5'd4, 5'd0, 3'b100), 32'd0, 1'b1,
      CK_AMT | CK_DLY, IT_NORMAL, OP2_VX, OP_AND, 1'b0, 2'd0, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vsll_vi", row_t'{S_IVI, enc_ar(6'b100101, 1'b1, 5'd6, 5'd9, 3'b011), 32'd0, 1'b0,
      CK_AMT, IT_NORMAL, OP2_VI, OP_SLL, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd36,
      3'd0, 3'd0, 32'd0});
   add_row("vmseq_vv_m", row_t'{S_IVV, enc_ar(6'b011000, 1'b0, 5'd7, 5'd8, 3'b000), 32'd0, 1'b0,
      CK_WDW, IT_NORMAL, OP2_VV, OP_SEQ, 1'b0, 2'd3, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vmul_vx", row_t'{S_MVX, enc_ar(6'b100101, 1'b1, 5'd2, 5'd10, 3'b110), 32'd0, 1'b1,
      CK_AMT | CK_DLY, IT_NORMAL, OP2_VX, OP_MUL, 1'b0, 2'd0, 8'd7, 1'b0, 1'b0, 32'd4,
      3'd0, 3'd0, 32'd0});
   add_row("vmacc_vv", row_t'{S_MVV, enc_ar(6'b101101, 1'b1, 5'd3, 5'd4, 3'b010), 32'd0, 1'b0,
      CK_DLY, IT_NORMAL, OP2_VV, OP_MUL_ADD, 1'b0, 2'd0, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vredsum_vs", row_t'{S_MVV, enc_ar(6'b000000, 1'b1, 5'd8, 5'd9, 3'b010), 32'd0, 1'b0,
      CK_DLY, IT_REDUCTION, OP2_VV, OP_ADD, 1'b1, 2'd0, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vredmaxu_vx", row_t'{S_MVX, enc_ar(6'b000110, 1'b1, 5'd8, 5'd0, 3'b110), 32'h1234,
      1'b0, CK_DLY, IT_REDUCTION, OP2_VX, OP_SGTU, 1'b1, 2'd0, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   // vset* rows, vl from avl, vlmax (m1, mf4, m8) or kept
   add_row("vsetvli_avl", row_t'{S_CFG, enc_cfg(2'b00, 3'd1, 3'd1, 5'd5, 5'd1), 32'd77, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd1, 3'd1, 32'd77});
   add_row("vsetvli_max", row_t'{S_CFG, enc_cfg(2'b00, 3'd0, 3'd0, 5'd0, 5'd2), 32'd0, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd512});
   add_row("vsetvli_mf4", row_t'{S_CFG, enc_cfg(2'b00, 3'd6, 3'd1, 5'd0, 5'd3), 32'd0, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd1, 3'd6, 32'd64});
   add_row("vsetvl_m8", row_t'{S_CFG, enc_cfg(2'b10, 3'd0, 3'd0, 5'd0, 5'd4), 32'h03, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd3, 32'd4096});
   add_row("vsetvli_keep", row_t'{S_CFG, enc_cfg(2'b00, 3'd0, 3'd2, 5'd0, 5'd0), 32'd0, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd2, 3'd0, 32'd4096});
   add_row("vsetvli_e16", row_t'{S_CFG, enc_cfg(2'b00, 3'd0, 3'd1, 5'd4, 5'd5), 32'd20, 1'b0,
      CK_CFG, IT_INVALID, OP2_NONE, OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd1, 3'd0, 32'd20});
   // e16 from here, widening and memory classes
   add_row("vwredsum_vs", row_t'{S_IVV, enc_ar(6'b110001, 1'b1, 5'd2, 5'd3, 3'b000), 32'd0, 1'b0,
      CK_WDW | CK_DLY, IT_REDUCTION, OP2_VV, OP_ADD, 1'b1, 2'd3, 8'd7, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vwaddu_vv_m", row_t'{S_MVV, enc_ar(6'b110000, 1'b0, 5'd4, 5'd6, 3'b010), 32'd0, 1'b0,
      CK_WDW, IT_NORMAL, OP2_VV, OP_ADDU, 1'b0, 2'd3, 8'd0, 1'b0, 1'b0, 32'd0,
      3'd0, 3'd0, 32'd0});
   add_row("vle32", row_t'{S_LD, 32'h02056087, 32'd0, 1'b0, 5'd0, IT_LOAD, OP2_NONE, OP_NONE,
      1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0, 3'd0, 3'd0, 32'd0});
   add_row("vluxei32", row_t'{S_ILD, 32'h06256087, 32'd0, 1'b0, 5'd0, IT_ILOAD, OP2_NONE, OP_NONE,
      1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0, 3'd0, 3'd0, 32'd0});
   add_row("vse32", row_t'{S_ST, 32'h020560a7, 32'd0, 1'b0, 5'd0, IT_STORE, OP2_NONE, OP_NONE,
      1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0, 3'd0, 3'd0, 32'd0});
   add_row("vsuxei32_m", row_t'{S_IST, 32'h042560a7, 32'd0, 1'b0, 5'd0, IT_ISTORE, OP2_NONE,
      OP_NONE, 1'b0, 2'd0, 8'd0, 1'b0, 1'b0, 32'd0, 3'd0, 3'd0, 32'd0});
   // slides, fast amount at e16 is 32
   add_row("vslideup_vi", row_t'{S_IVI, enc_ar(6'b001110, 1'b1, 5'd2, 5'd3, 3'b011), 32'd0, 1'b0,
      CK_ALL, IT_SLIDE, OP2_VI, OP_NONE, 1'b0, 2'd1, 8'd2, SLIDE_SLOW, 1'b1, 32'd6,
      3'd0, 3'd0, 32'd0});
   add_row("vslidedown_vx", row_t'{S_IVX, enc_ar(6'b001111, 1'b1, 5'd2, 5'd11, 3'b100), 32'd32,
      1'b0, CK_ALL, IT_SLIDE, OP2_VX, OP_NONE, 1'b0, 2'd2, 8'd2, SLIDE_FAST, 1'b0, 32'd64,
      3'd0, 3'd0, 32'd0});
   add_row("vslide1up_vx_m", row_t'{S_MVX, enc_ar(6'b001110, 1'b0, 5'd3, 5'd12, 3'b110), 32'd5,
      1'b0, CK_ALL, IT_SLIDE, OP2_VX, OP_NONE, 1'b0, 2'd1, 8'd2, SLIDE_SLOW, 1'b1, 32'd2,
      3'd0, 3'd0, 32'd0});
endtask

`endif

// ==== sim/v_cu_tb.sv ====
`timescale 1ns/1ps

module v_cu_tb
   import v_cu_pkg::*;
;

   localparam int VLEN      = 4096;
   localparam int VLANE_NUM = 16;
   localparam int DLY_W     = $clog2(VLEN/VLANE_NUM);

   // one strobe bit per class
   localparam logic [11:0] S_CFG = 12'b1 << CLS_CONFIG;
   localparam logic [11:0] S_IVX = 12'b1 << CLS_OPIVX;
   localparam logic [11:0] S_IVI = 12'b1 << CLS_OPIVI;
   localparam logic [11:0] S_IVV = 12'b1 << CLS_OPIVV;
   localparam logic [11:0] S_MVX = 12'b1 << CLS_OPMVX;
   localparam logic [11:0] S_MVV = 12'b1 << CLS_OPMVV;
   localparam logic [11:0] S_LD  = 12'b1 << CLS_LOAD;
   localparam logic [11:0] S_ILD = 12'b1 << CLS_ILOAD;
   localparam logic [11:0] S_ST  = 12'b1 << CLS_STORE;
   localparam logic [11:0] S_IST = 12'b1 << CLS_ISTORE;

   // which optional fields a row checks
   localparam logic [4:0] CK_AMT = 5'b00001;
   localparam logic [4:0] CK_WDW = 5'b00010;
   localparam logic [4:0] CK_DLY = 5'b00100;
   localparam logic [4:0] CK_CFG = 5'b01000;
   localparam logic [4:0] CK_SLD = 5'b10000;
   localparam logic [4:0] CK_ALL = 5'b10111;  // all but config

   typedef struct packed {
      logic [11:0] cls;
      logic [31:0] instr;
      logic [31:0] rs1;
      logic        rnd;    // rs1 from lcg
      logic [4:0]  chk;
      logic [2:0]  itype;
      logic [1:0]  op2;
      logic [8:0]  opm;
      logic        red;
      logic [1:0]  wdw;
      logic [7:0]  dly;
      logic        stype;
      logic        dir;    // 1 = up
      logic [31:0] amt;    // bytes
      logic [2:0]  sew;
      logic [2:0]  lmul;
      logic [31:0] vl;
   } row_t;

   logic clk = 1'b0;
   logic rstn;
   logic [11:0] instr_vld;
   logic [31:0] vector_instr;
   logic [31:0] scalar_rs1;
   logic [2:0]  sew, lmul, inst_type;
   logic [31:0] vl, alu_x_data, slide_amount;
   logic        reduction_op, vector_mask, slide_type, up_down_slide;
   logic [1:0]  op2_sel, wdata_width;
   logic [4:0]  alu_imm;
   logic [ALU_OPMODE_W-1:0] alu_opmode;
   logic [DLY_W-1:0]        inst_delay;

   row_t        rows [$];
   string       names [$];
   logic [31:0] lcg_state = 32'd74052;
   logic [2:0]  cur_sew = 3'd2;   // model of committed sew
   int          err_cnt = 0;
   int          n_tests = 0;
   int          n_failed = 0;

   always #10 clk = ~clk;  // 20 ns

   v_cu #(.VLEN(VLEN), .VLANE_NUM(VLANE_NUM)) uut (
      .clk(clk), .rstn(rstn), .instr_vld_i(instr_vld), .vector_instr_i(vector_instr),
      .scalar_rs1_i(scalar_rs1), .sew_o(sew), .lmul_o(lmul), .vl_o(vl),
      .inst_type_o(inst_type), .reduction_op_o(reduction_op), .op2_sel_o(op2_sel),
      .alu_x_data_o(alu_x_data), .alu_imm_o(alu_imm), .alu_opmode_o(alu_opmode),
      .vector_mask_o(vector_mask), .wdata_width_o(wdata_width), .inst_delay_o(inst_delay),
      .slide_type_o(slide_type), .up_down_slide_o(up_down_slide),
      .slide_amount_o(slide_amount)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // OPIV*/OPMV* word, vd fixed at v1
   function automatic logic [31:0] enc_ar(input logic [5:0] f6, input logic vm,
                                          input logic [4:0] vs2, input logic [4:0] vs1,
                                          input logic [2:0] f3);
      return {f6, vm, vs2, vs1, f3, 5'd1, 7'h57};
   endfunction

   // vsetvli / vsetvl word, vma and vta clear
   function automatic logic [31:0] enc_cfg(input logic [1:0] form, input logic [2:0] lmul_f,
                                           input logic [2:0] sew_f, input logic [4:0] rs1_f,
                                           input logic [4:0] rd_f);
      return {form, 4'b0000, lmul_f[2], sew_f, lmul_f[1:0], rs1_f, 3'b111, rd_f, 7'h57};
   endfunction

   task automatic add_row(input string nm, input row_t r);
      names.push_back(nm);
      rows.push_back(r);
   endtask

   task automatic check(input string test, input string field,
                        input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         err_cnt++;
         $display("[ERROR] %s %s expected %0h actual %0h", test, field, exp, act);
      end
   endtask

   task automatic report(input string nm, input int errs_before);
      n_tests++;
      if (err_cnt != errs_before)
         n_failed++;
      $display("%-16s %s", nm, (err_cnt == errs_before) ? "ok" : "FAILED");
   endtask

   `include "v_cu_tb_cases.svh"

   // drive at an edge, decode after the capture edge, vtype/vl one edge later
   task automatic run_row(input string nm, input row_t r);
      logic [31:0] rs1;
      logic [31:0] exp_amt;
      int          errs_before;
      rs1 = r.rnd ? lcg_next() : r.rs1;
      exp_amt = (r.rnd && r.cls == S_IVX) ? rs1 << cur_sew : r.amt;  // scalar slide amount
      errs_before = err_cnt;
      @(posedge clk);
      instr_vld    <= r.cls;
      vector_instr <= r.instr;
      scalar_rs1   <= rs1;
      @(posedge clk);
      instr_vld <= '0;  // idle again
      @(negedge clk);
      check(nm, "inst_type", 32'(r.itype), 32'(inst_type));
      check(nm, "op2_sel", 32'(r.op2), 32'(op2_sel));
      check(nm, "alu_opmode", 32'(r.opm), 32'(alu_opmode));
      check(nm, "reduction_op", 32'(r.red), 32'(reduction_op));
      check(nm, "vector_mask", {31'd0, ~r.instr[25]}, 32'(vector_mask));
      check(nm, "alu_imm", 32'(r.instr[19:15]), 32'(alu_imm));
      check(nm, "alu_x_data", rs1, alu_x_data);
      if (|(r.chk & CK_AMT))
         check(nm, "slide_amount", exp_amt, slide_amount);
      if (|(r.chk & CK_WDW))
         check(nm, "wdata_width", 32'(r.wdw), 32'(wdata_width));
      if (|(r.chk & CK_DLY))
         check(nm, "inst_delay", 32'(r.dly), 32'(inst_delay));
      if (|(r.chk & CK_SLD))
      begin
         check(nm, "slide_type", 32'(r.stype), 32'(slide_type));
         check(nm, "up_down_slide", 32'(r.dir), 32'(up_down_slide));
      end
      @(posedge clk);
      @(negedge clk);
      if (|(r.chk & CK_CFG))
      begin
         check(nm, "sew", 32'(r.sew), 32'(sew));
         check(nm, "lmul", 32'(r.lmul), 32'(lmul));
         check(nm, "vl", r.vl, vl);
         cur_sew = r.sew;
      end
      report(nm, errs_before);
   endtask

   initial
   begin
      int errs_before;
      rstn         = 1'b0;
      instr_vld    = '0;
      vector_instr = '0;
      scalar_rs1   = '0;
      fill_table();
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      errs_before = err_cnt;
      check("reset", "sew", 32'd2, 32'(sew));  // e32, m1
      check("reset", "lmul", 32'd0, 32'(lmul));
      check("reset", "vl", 32'(VLEN/32), vl);
      check("reset", "inst_type", 32'(IT_INVALID), 32'(inst_type));
      check("reset", "alu_opmode", 32'(OP_NONE), 32'(alu_opmode));
      check("reset", "op2_sel", 32'(OP2_NONE), 32'(op2_sel));
      check("reset", "reduction_op", 32'd0, 32'(reduction_op));
      report("reset", errs_before);
      for (int i = 0; i < rows.size(); i++)
         run_row(names[i], rows[i]);
      $display("%0d tests, %0d failed, %0d mismatches", n_tests, n_failed, err_cnt);
      if (err_cnt == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // 3 cycles per row used, 4 allowed, plus reset and slack
   initial
   begin
      int unsigned limit_ns;
      #1;
      limit_ns = (rows.size() * 4 + 8 + 20) * 20;
      #(limit_ns);
      $display("timeout: test loop did not finish within %0d ns", limit_ns);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+include
logic/v_cu_pkg.sv
logic/v_instr_decode.sv
logic/v_config_unit.sv
logic/v_alu_opmode_decoder.sv
logic/v_slide_ctrl.sv
logic/v_cu.sv
sim/v_cu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= v_cu_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
